// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_id_stage
FILELIST  := tb.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^SIMULATION PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    import la32_isa_pkg::*;

    localparam int ALU_OP_W  = 8;
    localparam int ALU_SEL_W = 3;
    localparam int DEC_NUM   = 3;   // Format decoders in the stage

    typedef logic [ALU_OP_W-1:0]  alu_op_t;
    typedef logic [ALU_SEL_W-1:0] alu_sel_t;

    // ALU operation codes, NOP must stay all zero
    localparam alu_op_t ALU_OP_NOP       = 8'h00;
    localparam alu_op_t ALU_OP_ADD       = 8'h01;
    localparam alu_op_t ALU_OP_SUB       = 8'h02;
    localparam alu_op_t ALU_OP_SLT       = 8'h03;
    localparam alu_op_t ALU_OP_SLTU      = 8'h04;
    localparam alu_op_t ALU_OP_AND       = 8'h05;
    localparam alu_op_t ALU_OP_OR        = 8'h06;
    localparam alu_op_t ALU_OP_XOR       = 8'h07;
    localparam alu_op_t ALU_OP_NOR       = 8'h08;
    localparam alu_op_t ALU_OP_SLL       = 8'h09;
    localparam alu_op_t ALU_OP_SRL       = 8'h0a;
    localparam alu_op_t ALU_OP_SRA       = 8'h0b;
    localparam alu_op_t ALU_OP_MUL       = 8'h0c;
    localparam alu_op_t ALU_OP_LUI       = 8'h0d;
    localparam alu_op_t ALU_OP_PCADDU12I = 8'h0e;
    localparam alu_op_t ALU_OP_LD_B      = 8'h10;
    localparam alu_op_t ALU_OP_LD_H      = 8'h11;
    localparam alu_op_t ALU_OP_LD_W      = 8'h12;
    localparam alu_op_t ALU_OP_LD_BU     = 8'h13;
    localparam alu_op_t ALU_OP_LD_HU     = 8'h14;
    localparam alu_op_t ALU_OP_ST_B      = 8'h18;
    localparam alu_op_t ALU_OP_ST_H      = 8'h19;
    localparam alu_op_t ALU_OP_ST_W      = 8'h1a;

    // Result select
    localparam alu_sel_t ALU_SEL_NOP        = 3'd0;
    localparam alu_sel_t ALU_SEL_LOGIC      = 3'd1;
    localparam alu_sel_t ALU_SEL_SHIFT      = 3'd2;
    localparam alu_sel_t ALU_SEL_ARITH      = 3'd3;
    localparam alu_sel_t ALU_SEL_LOAD_STORE = 3'd4;

    // Instruction buffer entry
    typedef struct packed {
        addr_t  pc;
        instr_t instr;
    } instr_info_t;

    // Index 0 is rj, index 1 is rk or rd
    typedef struct packed {
        logic                hit;
        logic [1:0]          reg_read_valid;
        reg_idx_t [1:0]      reg_read_addr;
        logic                use_imm;
        data_t               imm;
        logic                reg_write_valid;
        reg_idx_t            reg_write_addr;
        alu_op_t             aluop;
        alu_sel_t            alusel;
    } decode_result_t;

    typedef struct packed {
        addr_t               pc;
        logic                illegal;
        logic [1:0]          reg_read_valid;
        reg_idx_t [1:0]      reg_read_addr;
        logic                use_imm;
        data_t               imm;
        logic                reg_write_valid;
        reg_idx_t            reg_write_addr;
        alu_op_t             aluop;
        alu_sel_t            alusel;
    } decoded_op_t;

endpackage

`default_nettype wire

// ==== hdl/decoder_1ri20.sv ====
`timescale 1ns/1ps
`default_nettype none

// 1RI20 format {opcode[7], imm[20], rd[5]}
module decoder_1ri20
    import la32_isa_pkg::*;
    import decode_pkg::*;
(
    input  wire instr_t    instr_i,
    output decode_result_t result_o
);

    reg_idx_t   rd;
    imm20_t     imm20;
    opc_1ri20_t opcode;
    logic       is_lu12i;
    logic       is_pcaddu12i;

    assign rd     = instr_i[RD_LSB +: REG_IDX_W];
    assign imm20  = instr_i[IMM20_LSB +: IMM20_W];
    assign opcode = instr_i[OPC_1RI20_LSB +: OPC_1RI20_W];

    assign is_lu12i     = (opcode == OPC_1RI20_LU12I_W);
    assign is_pcaddu12i = (opcode == OPC_1RI20_PCADDU12I);

    always_comb begin
        result_o = '0;
        if (is_lu12i || is_pcaddu12i) begin
            result_o.hit             = 1'b1;
            result_o.use_imm         = 1'b1;
            result_o.imm             = {imm20, {(DATA_W-IMM20_W){1'b0}}};  // Upper 20 bits
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = rd;
            result_o.alusel          = ALU_SEL_ARITH;
            // pcaddu12i adds the PC later in the pipe
            result_o.aluop           = is_lu12i ? ALU_OP_LUI : ALU_OP_PCADDU12I;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/decoder_2ri12.sv ====
`timescale 1ns/1ps
`default_nettype none

// 2RI12 format {opcode[10], imm[12], rj[5], rd[5]}
module decoder_2ri12
    import la32_isa_pkg::*;
    import decode_pkg::*;
(
    input  wire instr_t    instr_i,
    output decode_result_t result_o
);

    reg_idx_t   rd;
    reg_idx_t   rj;
    imm12_t     imm12;
    opc_2ri12_t opcode;
    data_t      imm_sext;
    data_t      imm_zext;
    alu_op_t    aluop;
    alu_sel_t   alusel;
    logic       is_store;
    logic       is_preld;
    logic       is_zext;
    logic       is_imm_alu;
    logic       hit;

    assign rd     = instr_i[RD_LSB +: REG_IDX_W];
    assign rj     = instr_i[RJ_LSB +: REG_IDX_W];
    assign imm12  = instr_i[IMM12_LSB +: IMM12_W];
    assign opcode = instr_i[OPC_2RI12_LSB +: OPC_2RI12_W];

    assign imm_sext = {{(DATA_W-IMM12_W){imm12[IMM12_W-1]}}, imm12};
    assign imm_zext = {{(DATA_W-IMM12_W){1'b0}}, imm12};

    // Opcode to ALU operation
    always_comb begin
        aluop  = ALU_OP_NOP;
        alusel = ALU_SEL_NOP;
        case (opcode)
            OPC_2RI12_SLTI:   {aluop, alusel} = {ALU_OP_SLT, ALU_SEL_ARITH};
            OPC_2RI12_SLTUI:  {aluop, alusel} = {ALU_OP_SLTU, ALU_SEL_ARITH};
            OPC_2RI12_ADDI_W: {aluop, alusel} = {ALU_OP_ADD, ALU_SEL_ARITH};
            OPC_2RI12_ANDI:   {aluop, alusel} = {ALU_OP_AND, ALU_SEL_LOGIC};
            OPC_2RI12_ORI:    {aluop, alusel} = {ALU_OP_OR, ALU_SEL_LOGIC};
            OPC_2RI12_XORI:   {aluop, alusel} = {ALU_OP_XOR, ALU_SEL_LOGIC};
            OPC_2RI12_LD_B:   {aluop, alusel} = {ALU_OP_LD_B, ALU_SEL_LOAD_STORE};
            OPC_2RI12_LD_H:   {aluop, alusel} = {ALU_OP_LD_H, ALU_SEL_LOAD_STORE};
            OPC_2RI12_LD_W:   {aluop, alusel} = {ALU_OP_LD_W, ALU_SEL_LOAD_STORE};
            OPC_2RI12_LD_BU:  {aluop, alusel} = {ALU_OP_LD_BU, ALU_SEL_LOAD_STORE};
            OPC_2RI12_LD_HU:  {aluop, alusel} = {ALU_OP_LD_HU, ALU_SEL_LOAD_STORE};
            OPC_2RI12_ST_B:   {aluop, alusel} = {ALU_OP_ST_B, ALU_SEL_LOAD_STORE};
            OPC_2RI12_ST_H:   {aluop, alusel} = {ALU_OP_ST_H, ALU_SEL_LOAD_STORE};
            OPC_2RI12_ST_W:   {aluop, alusel} = {ALU_OP_ST_W, ALU_SEL_LOAD_STORE};
            default: ;        // preld stays NOP
        endcase
    end

    assign is_store   = opcode inside {OPC_2RI12_ST_B, OPC_2RI12_ST_H, OPC_2RI12_ST_W};
    assign is_preld   = (opcode == OPC_2RI12_PRELD);
    assign is_zext    = opcode inside {OPC_2RI12_ANDI, OPC_2RI12_ORI, OPC_2RI12_XORI};
    assign is_imm_alu = (alusel == ALU_SEL_ARITH) || (alusel == ALU_SEL_LOGIC);
    assign hit        = (alusel != ALU_SEL_NOP) || is_preld;

    always_comb begin
        result_o = '0;  // No hit, everything cleared
        if (hit) begin
            result_o.hit               = 1'b1;
            result_o.reg_read_valid[0] = 1'b1;  // rj is the base or operand
            result_o.reg_read_addr[0]  = rj;
            result_o.use_imm           = is_imm_alu;
            result_o.aluop             = aluop;
            result_o.alusel            = alusel;

            // Stores read rd as data, preld writes nothing
            if (is_store) begin
                result_o.reg_read_valid[1] = 1'b1;
                result_o.reg_read_addr[1]  = rd;
            end else if (!is_preld) begin
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr  = rd;
            end

            if (!is_preld) begin
                result_o.imm = is_zext ? imm_zext : imm_sext;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/decoder_3r.sv ====
`timescale 1ns/1ps
`default_nettype none

// 3R format {opcode[17], rk[5], rj[5], rd[5]}
module decoder_3r
    import la32_isa_pkg::*;
    import decode_pkg::*;
(
    input  wire instr_t    instr_i,
    output decode_result_t result_o
);

    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    opc_3r_t  opcode;
    alu_op_t  aluop;
    alu_sel_t alusel;
    logic     hit;

    assign rd     = instr_i[RD_LSB +: REG_IDX_W];
    assign rj     = instr_i[RJ_LSB +: REG_IDX_W];
    assign rk     = instr_i[RK_LSB +: REG_IDX_W];
    assign opcode = instr_i[OPC_3R_LSB +: OPC_3R_W];

    always_comb begin
        aluop  = ALU_OP_NOP;
        alusel = ALU_SEL_NOP;
        case (opcode)
            // Arithmetic, mul.w goes through the same result path
            OPC_3R_ADD_W: {aluop, alusel} = {ALU_OP_ADD, ALU_SEL_ARITH};
            OPC_3R_SUB_W: {aluop, alusel} = {ALU_OP_SUB, ALU_SEL_ARITH};
            OPC_3R_SLT:   {aluop, alusel} = {ALU_OP_SLT, ALU_SEL_ARITH};
            OPC_3R_SLTU:  {aluop, alusel} = {ALU_OP_SLTU, ALU_SEL_ARITH};
            OPC_3R_MUL_W: {aluop, alusel} = {ALU_OP_MUL, ALU_SEL_ARITH};

            // Logic
            OPC_3R_NOR:   {aluop, alusel} = {ALU_OP_NOR, ALU_SEL_LOGIC};
            OPC_3R_AND:   {aluop, alusel} = {ALU_OP_AND, ALU_SEL_LOGIC};
            OPC_3R_OR:    {aluop, alusel} = {ALU_OP_OR, ALU_SEL_LOGIC};
            OPC_3R_XOR:   {aluop, alusel} = {ALU_OP_XOR, ALU_SEL_LOGIC};

            // Shifts by rk
            OPC_3R_SLL_W: {aluop, alusel} = {ALU_OP_SLL, ALU_SEL_SHIFT};
            OPC_3R_SRL_W: {aluop, alusel} = {ALU_OP_SRL, ALU_SEL_SHIFT};
            OPC_3R_SRA_W: {aluop, alusel} = {ALU_OP_SRA, ALU_SEL_SHIFT};
            default: ;
        endcase
    end

    assign hit = (alusel != ALU_SEL_NOP);

    always_comb begin
        result_o = '0;
        if (hit) begin
            result_o.hit             = 1'b1;
            result_o.reg_read_valid  = 2'b11;  // {rk, rj}
            result_o.reg_read_addr   = {rk, rj};
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = rd;
            result_o.aluop           = aluop;
            result_o.alusel          = alusel;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage
    import decode_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n_i,

    input  wire logic        in_valid_i,
    output logic             in_ready_o,
    input  wire instr_info_t in_info_i,

    output logic             out_valid_o,
    input  wire logic        out_ready_i,
    output decoded_op_t      out_op_o
);

    decode_result_t               dec_res [DEC_NUM];
    decode_result_t               merged;
    logic                         any_hit;
    logic                         accept;
    decoded_op_t                  op_d;
    decoded_op_t                  out_op_q;
    logic                         out_valid_q;

    decoder_2ri12 u_dec_2ri12 (
        .instr_i  (in_info_i.instr),
        .result_o (dec_res[0])
    );

    decoder_3r u_dec_3r (
        .instr_i  (in_info_i.instr),
        .result_o (dec_res[1])
    );

    decoder_1ri20 u_dec_1ri20 (
        .instr_i  (in_info_i.instr),
        .result_o (dec_res[2])
    );

    // Opcodes are disjoint, so at most one decoder hits
    always_comb begin
        merged  = '0;
        any_hit = 1'b0;
        for (int i = 0; i < DEC_NUM; i++) begin
            merged  = merged | (dec_res[i] & {$bits(decode_result_t){dec_res[i].hit}});
            any_hit = any_hit | dec_res[i].hit;
        end
    end

    // Unknown word leaves merged all zero, so masks and codes read as NOP
    always_comb begin
        op_d.pc              = in_info_i.pc;
        op_d.illegal         = !any_hit;
        op_d.reg_read_valid  = merged.reg_read_valid;
        op_d.reg_read_addr   = merged.reg_read_addr;
        op_d.use_imm         = merged.use_imm;
        op_d.imm             = merged.imm;
        op_d.reg_write_valid = merged.reg_write_valid;
        op_d.reg_write_addr  = merged.reg_write_addr;
        op_d.aluop           = merged.aluop;
        op_d.alusel          = merged.alusel;
    end

    assign in_ready_o = !out_valid_q || out_ready_i;  // Empty or draining
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (accept) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    // Payload only moves on a transfer, holds while stalled
    always_ff @(posedge clk) begin
        if (accept) begin
            out_op_q <= op_d;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_op_o    = out_op_q;

endmodule

`default_nettype wire

// ==== hdl/la32_isa_pkg.sv ====
`default_nettype none

package la32_isa_pkg;

    // Architectural widths
    localparam int INSTR_W   = 32;
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int GPR_NUM   = 32;
    localparam int REG_IDX_W = $clog2(GPR_NUM);

    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Register fields, same place in every format
    localparam int RD_LSB = 0;
    localparam int RJ_LSB = 5;
    localparam int RK_LSB = 10;   // 3R only

    // Immediate fields
    localparam int IMM12_LSB = 10;
    localparam int IMM12_W   = 12;
    localparam int IMM20_LSB = 5;
    localparam int IMM20_W   = 20;

    typedef logic [IMM12_W-1:0] imm12_t;
    typedef logic [IMM20_W-1:0] imm20_t;

    // Major opcode fields, all ending at bit 31
    localparam int OPC_2RI12_LSB = 22;
    localparam int OPC_2RI12_W   = 10;
    localparam int OPC_3R_LSB    = 15;
    localparam int OPC_3R_W      = 17;
    localparam int OPC_1RI20_LSB = 25;
    localparam int OPC_1RI20_W   = 7;

    typedef logic [OPC_2RI12_W-1:0] opc_2ri12_t;
    typedef logic [OPC_3R_W-1:0]    opc_3r_t;
    typedef logic [OPC_1RI20_W-1:0] opc_1ri20_t;

    // 2RI12 {opcode[10], imm[12], rj[5], rd[5]}
    localparam opc_2ri12_t OPC_2RI12_SLTI   = 10'h008;
    localparam opc_2ri12_t OPC_2RI12_SLTUI  = 10'h009;
    localparam opc_2ri12_t OPC_2RI12_ADDI_W = 10'h00a;
    localparam opc_2ri12_t OPC_2RI12_ANDI   = 10'h00d;
    localparam opc_2ri12_t OPC_2RI12_ORI    = 10'h00e;
    localparam opc_2ri12_t OPC_2RI12_XORI   = 10'h00f;
    localparam opc_2ri12_t OPC_2RI12_LD_B   = 10'h0a0;
    localparam opc_2ri12_t OPC_2RI12_LD_H   = 10'h0a1;
    localparam opc_2ri12_t OPC_2RI12_LD_W   = 10'h0a2;
    localparam opc_2ri12_t OPC_2RI12_ST_B   = 10'h0a4;
    localparam opc_2ri12_t OPC_2RI12_ST_H   = 10'h0a5;
    localparam opc_2ri12_t OPC_2RI12_ST_W   = 10'h0a6;
    localparam opc_2ri12_t OPC_2RI12_LD_BU  = 10'h0a8;
    localparam opc_2ri12_t OPC_2RI12_LD_HU  = 10'h0a9;
    localparam opc_2ri12_t OPC_2RI12_PRELD  = 10'h0ab;

    // 3R {opcode[17], rk[5], rj[5], rd[5]}
    localparam opc_3r_t OPC_3R_ADD_W = 17'h00020;
    localparam opc_3r_t OPC_3R_SUB_W = 17'h00022;
    localparam opc_3r_t OPC_3R_SLT   = 17'h00024;
    localparam opc_3r_t OPC_3R_SLTU  = 17'h00025;
    localparam opc_3r_t OPC_3R_NOR   = 17'h00028;
    localparam opc_3r_t OPC_3R_AND   = 17'h00029;
    localparam opc_3r_t OPC_3R_OR    = 17'h0002a;
    localparam opc_3r_t OPC_3R_XOR   = 17'h0002b;
    localparam opc_3r_t OPC_3R_SLL_W = 17'h0002e;
    localparam opc_3r_t OPC_3R_SRL_W = 17'h0002f;
    localparam opc_3r_t OPC_3R_SRA_W = 17'h00030;
    localparam opc_3r_t OPC_3R_MUL_W = 17'h00038;

    // 1RI20 {opcode[7], imm[20], rd[5]}
    localparam opc_1ri20_t OPC_1RI20_LU12I_W   = 7'h0a;
    localparam opc_1ri20_t OPC_1RI20_PCADDU12I = 7'h0e;

endpackage

`default_nettype wire

// ==== sim/tb_id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage
    import la32_isa_pkg::*;
    import decode_pkg::*;
();

    localparam int NUM_XFERS   = 3000;
    localparam int TIMEOUT_CYC = 4 * NUM_XFERS + 100;

    // Decode classes of the reference model
    localparam logic [2:0] K_NONE  = 3'd0;
    localparam logic [2:0] K_3R    = 3'd1;
    localparam logic [2:0] K_U20   = 3'd2;
    localparam logic [2:0] K_SEXT  = 3'd3;
    localparam logic [2:0] K_ZEXT  = 3'd4;
    localparam logic [2:0] K_LOAD  = 3'd5;
    localparam logic [2:0] K_STORE = 3'd6;
    localparam logic [2:0] K_PRELD = 3'd7;

    localparam opc_2ri12_t TAB_2RI12 [15] = '{OPC_2RI12_SLTI, OPC_2RI12_SLTUI, OPC_2RI12_ADDI_W,
        OPC_2RI12_ANDI, OPC_2RI12_ORI, OPC_2RI12_XORI, OPC_2RI12_LD_B, OPC_2RI12_LD_H,
        OPC_2RI12_LD_W, OPC_2RI12_LD_BU, OPC_2RI12_LD_HU, OPC_2RI12_ST_B, OPC_2RI12_ST_H,
        OPC_2RI12_ST_W, OPC_2RI12_PRELD};
    localparam opc_3r_t TAB_3R [12] = '{OPC_3R_ADD_W, OPC_3R_SUB_W, OPC_3R_SLT, OPC_3R_SLTU,
        OPC_3R_NOR, OPC_3R_AND, OPC_3R_OR, OPC_3R_XOR, OPC_3R_SLL_W, OPC_3R_SRL_W,
        OPC_3R_SRA_W, OPC_3R_MUL_W};
    localparam opc_1ri20_t TAB_1RI20 [2] = '{OPC_1RI20_LU12I_W, OPC_1RI20_PCADDU12I};

    logic        clk;
    logic        arst_n_i;
    logic        in_valid_i;
    logic        in_ready_o;
    instr_info_t in_info_i;
    logic        out_valid_o;
    logic        out_ready_i;
    decoded_op_t out_op_o;

    logic [31:0] rng = 32'h69ae_1e80;
    decoded_op_t exp_q [$];
    decoded_op_t exp_op;
    decoded_op_t last_exp;
    decoded_op_t held_op;
    logic        exp_valid;
    logic        in_hs       = 1'b0;  // Input transfer at the coming edge
    logic        expect_new  = 1'b0;
    logic        expect_hold = 1'b0;
    int          in_count    = 0;
    int          out_count   = 0;
    int          cycles      = 0;
    addr_t       pc_next     = 32'h1c00_0000;
    logic [31:0] sel_rand;
    logic [31:0] word_rand;

    id_stage dut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_info_i   (in_info_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_op_o    (out_op_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic compare_op(input decoded_op_t got, input decoded_op_t exp);
        check_val("pc", 128'(got.pc), 128'(exp.pc));
        check_val("illegal", 128'(got.illegal), 128'(exp.illegal));
        check_val("reg_read_valid", 128'(got.reg_read_valid), 128'(exp.reg_read_valid));
        check_val("reg_read_addr", 128'(got.reg_read_addr), 128'(exp.reg_read_addr));
        check_val("use_imm", 128'(got.use_imm), 128'(exp.use_imm));
        check_val("imm", 128'(got.imm), 128'(exp.imm));
        check_val("reg_write_valid", 128'(got.reg_write_valid), 128'(exp.reg_write_valid));
        check_val("reg_write_addr", 128'(got.reg_write_addr), 128'(exp.reg_write_addr));
        check_val("aluop", 128'(got.aluop), 128'(exp.aluop));
        check_val("alusel", 128'(got.alusel), 128'(exp.alusel));
    endtask

    // 80 % table opcodes with random fields and 20 % fully random words
    function automatic instr_t make_word(input logic [31:0] pick, input logic [31:0] r);
        int idx;
        idx = int'((pick / 10) % 29);
        if ((pick % 10) >= 8) begin
            return r;
        end else if (idx < 15) begin
            return {TAB_2RI12[idx], r[21:0]};
        end else if (idx < 27) begin
            return {TAB_3R[idx-15], r[14:0]};
        end else begin
            return {TAB_1RI20[idx-27], r[24:0]};
        end
    endfunction

    // Reference decode written from the ISA field layout
    function automatic decoded_op_t ref_decode(input instr_info_t e);
        decoded_op_t o;
        reg_idx_t    rd;
        reg_idx_t    rj;
        reg_idx_t    rk;
        logic [11:0] i12;
        logic [2:0]  kind;
        alu_op_t     op;
        alu_sel_t    sel;
        rd   = e.instr[4:0];
        rj   = e.instr[9:5];
        rk   = e.instr[14:10];
        i12  = e.instr[21:10];
        {kind, op, sel} = {K_NONE, ALU_OP_NOP, ALU_SEL_NOP};
        case (e.instr[31:15])
            OPC_3R_ADD_W: {kind, op, sel} = {K_3R, ALU_OP_ADD, ALU_SEL_ARITH};
            OPC_3R_SUB_W: {kind, op, sel} = {K_3R, ALU_OP_SUB, ALU_SEL_ARITH};
            OPC_3R_SLT:   {kind, op, sel} = {K_3R, ALU_OP_SLT, ALU_SEL_ARITH};
            OPC_3R_SLTU:  {kind, op, sel} = {K_3R, ALU_OP_SLTU, ALU_SEL_ARITH};
            OPC_3R_MUL_W: {kind, op, sel} = {K_3R, ALU_OP_MUL, ALU_SEL_ARITH};
            OPC_3R_NOR:   {kind, op, sel} = {K_3R, ALU_OP_NOR, ALU_SEL_LOGIC};
            OPC_3R_AND:   {kind, op, sel} = {K_3R, ALU_OP_AND, ALU_SEL_LOGIC};
            OPC_3R_OR:    {kind, op, sel} = {K_3R, ALU_OP_OR, ALU_SEL_LOGIC};
            OPC_3R_XOR:   {kind, op, sel} = {K_3R, ALU_OP_XOR, ALU_SEL_LOGIC};
            OPC_3R_SLL_W: {kind, op, sel} = {K_3R, ALU_OP_SLL, ALU_SEL_SHIFT};
            OPC_3R_SRL_W: {kind, op, sel} = {K_3R, ALU_OP_SRL, ALU_SEL_SHIFT};
            OPC_3R_SRA_W: {kind, op, sel} = {K_3R, ALU_OP_SRA, ALU_SEL_SHIFT};
            default: ;
        endcase
        case (e.instr[31:25])
            OPC_1RI20_LU12I_W:   {kind, op, sel} = {K_U20, ALU_OP_LUI, ALU_SEL_ARITH};
            OPC_1RI20_PCADDU12I: {kind, op, sel} = {K_U20, ALU_OP_PCADDU12I, ALU_SEL_ARITH};
            default: ;
        endcase
        case (e.instr[31:22])
            OPC_2RI12_SLTI:   {kind, op, sel} = {K_SEXT, ALU_OP_SLT, ALU_SEL_ARITH};
            OPC_2RI12_SLTUI:  {kind, op, sel} = {K_SEXT, ALU_OP_SLTU, ALU_SEL_ARITH};
            OPC_2RI12_ADDI_W: {kind, op, sel} = {K_SEXT, ALU_OP_ADD, ALU_SEL_ARITH};
            OPC_2RI12_ANDI:   {kind, op, sel} = {K_ZEXT, ALU_OP_AND, ALU_SEL_LOGIC};
            OPC_2RI12_ORI:    {kind, op, sel} = {K_ZEXT, ALU_OP_OR, ALU_SEL_LOGIC};
            OPC_2RI12_XORI:   {kind, op, sel} = {K_ZEXT, ALU_OP_XOR, ALU_SEL_LOGIC};
            OPC_2RI12_LD_B:   {kind, op, sel} = {K_LOAD, ALU_OP_LD_B, ALU_SEL_LOAD_STORE};
            OPC_2RI12_LD_H:   {kind, op, sel} = {K_LOAD, ALU_OP_LD_H, ALU_SEL_LOAD_STORE};
            OPC_2RI12_LD_W:   {kind, op, sel} = {K_LOAD, ALU_OP_LD_W, ALU_SEL_LOAD_STORE};
            OPC_2RI12_LD_BU:  {kind, op, sel} = {K_LOAD, ALU_OP_LD_BU, ALU_SEL_LOAD_STORE};
            OPC_2RI12_LD_HU:  {kind, op, sel} = {K_LOAD, ALU_OP_LD_HU, ALU_SEL_LOAD_STORE};
            OPC_2RI12_ST_B:   {kind, op, sel} = {K_STORE, ALU_OP_ST_B, ALU_SEL_LOAD_STORE};
            OPC_2RI12_ST_H:   {kind, op, sel} = {K_STORE, ALU_OP_ST_H, ALU_SEL_LOAD_STORE};
            OPC_2RI12_ST_W:   {kind, op, sel} = {K_STORE, ALU_OP_ST_W, ALU_SEL_LOAD_STORE};
            OPC_2RI12_PRELD:  {kind, op, sel} = {K_PRELD, ALU_OP_NOP, ALU_SEL_NOP};
            default: ;
        endcase

        o         = '0;
        o.pc      = e.pc;
        o.illegal = (kind == K_NONE);
        o.aluop   = op;
        o.alusel  = sel;
        if (kind != K_NONE && kind != K_U20) begin
            o.reg_read_valid[0] = 1'b1;  // rj
            o.reg_read_addr[0]  = rj;
        end
        if (kind == K_3R) begin
            o.reg_read_valid[1] = 1'b1;
            o.reg_read_addr[1]  = rk;
        end else if (kind == K_STORE) begin
            o.reg_read_valid[1] = 1'b1;  // Store data
            o.reg_read_addr[1]  = rd;
        end
        if (kind inside {K_3R, K_U20, K_SEXT, K_ZEXT, K_LOAD}) begin
            o.reg_write_valid = 1'b1;
            o.reg_write_addr  = rd;
        end
        o.use_imm = kind inside {K_U20, K_SEXT, K_ZEXT};
        if (kind == K_U20) begin
            o.imm = {e.instr[24:5], 12'h000};
        end else if (kind == K_ZEXT) begin
            o.imm = {20'h0, i12};
        end else if (kind inside {K_SEXT, K_LOAD, K_STORE}) begin
            o.imm = {{20{i12[11]}}, i12};
        end
        return o;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            fail_run($sformatf("timeout, output stopped delivering after %0d of %0d transfers",
                               out_count, NUM_XFERS));
        end
    end

    // Scoreboard on the falling edge, where all signals are settled
    always @(negedge clk) begin
        if (arst_n_i) begin
            exp_valid = (exp_q.size() != 0);  // Register holds one entry at most
            check_val("out_valid_o", 128'(out_valid_o), 128'(exp_valid));
            check_val("in_ready_o", 128'(in_ready_o), 128'(!exp_valid || out_ready_i));
            if (expect_new) begin   // One-cycle latency
                compare_op(out_op_o, last_exp);
            end else if (expect_hold) begin
                check_val("out_op_o", 128'(out_op_o), 128'(held_op));
            end
            expect_new  = 1'b0;
            expect_hold = 1'b0;
            if (exp_valid && out_ready_i) begin
                exp_op = exp_q.pop_front();
                compare_op(out_op_o, exp_op);
                out_count++;
            end else if (exp_valid) begin
                expect_hold = 1'b1;
                held_op     = out_op_o;
            end
            in_hs = in_valid_i && in_ready_o;
            if (in_hs) begin
                last_exp = ref_decode(in_info_i);
                exp_q.push_back(last_exp);
                expect_new = 1'b1;
                in_count++;
            end
        end
    end

    initial begin
        in_valid_i  = 1'b0;
        out_ready_i = 1'b0;
        in_info_i   = '0;
        arst_n_i    = 1'b1;
        #1 arst_n_i = 1'b0;
        repeat (2) @(posedge clk);
        check_val("out_valid_o", 128'(out_valid_o), 128'd0);
        check_val("in_ready_o", 128'(in_ready_o), 128'd1);
        arst_n_i <= 1'b1;
        while (out_count < NUM_XFERS) begin
            @(posedge clk);
            out_ready_i <= (rand32() % 10) < 7;  // About 30 % back-pressure
            if (!in_valid_i || in_hs) begin
                if (in_count < NUM_XFERS && (rand32() % 4) != 0) begin
                    sel_rand   = rand32();
                    word_rand  = rand32();
                    in_valid_i <= 1'b1;
                    in_info_i  <= {pc_next, make_word(sel_rand, word_rand)};
                    pc_next    = pc_next + 32'd4;
                end else begin
                    in_valid_i <= 1'b0;
                end
            end
        end
        // Let the scoreboard see the drained register first
        @(negedge clk);
        #1;
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/la32_isa_pkg.sv
hdl/decode_pkg.sv
hdl/decoder_2ri12.sv
hdl/decoder_3r.sv
hdl/decoder_1ri20.sv
hdl/id_stage.sv
sim/tb_id_stage.sv
